/* flist.f */
common/fc_pkg.sv
rtl/fc_decode.sv
mac/fc_mac_lane.sv
rtl/fc_requant.sv
rtl/fc_top.sv
tests/fc_assert.sv
tests/tb_fc.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the FC core testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fc \
  -f flist.f \
  -o sim_fc

./obj_dir/sim_fc 2>&1 | tee sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation finished without failures"

/* tests/tb_fc.sv */
// Testbench for the FC core. Sends random bias/data vectors with idle gaps
// and output back-pressure, and checks each result word against a queue model.
`timescale 1ns/1ns

module tb_fc;
  import fc_pkg::*;

  localparam int VECTORS   = 40;
  localparam int MAX_BEATS = 16;
  localparam int TIMEOUT   = VECTORS * (MAX_BEATS + 2) * 4 + 500;

  logic     clk;
  logic     rstn;
  in_beat_t s_beat;
  logic     s_valid;
  logic     s_ready;
  result_t  m_result;
  logic     m_valid;
  logic     m_ready;

  integer   seed;
  int       cycles;
  int       checked;
  result_t  exp_q [$];

  fc_top i_dut (
    .clk      (clk),
    .rstn     (rstn),
    .s_beat   (s_beat),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .m_result (m_result),
    .m_valid  (m_valid),
    .m_ready  (m_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run;
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: m_result got %h expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: s_ready got %b expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // ReLU, then saturate when anything above the output window is set
  function automatic logic [DATA_W-1:0] requant_byte(input int sum);
    if (sum < 0) begin
      return '0;
    end else if (sum >= (1 << (Q_MSB + 1))) begin
      return DATA_W'(SAT_VAL);
    end else begin
      return DATA_W'((sum >> Q_LSB) % (1 << (Q_MSB - Q_LSB + 1)));
    end
  endfunction

  // Lowest lane wins a tie
  function automatic result_t model_result(input int sums [LANES]);
    result_t r;
    int      best;

    best      = -1;
    r.max_idx = '0;
    for (int i = 0; i < LANES; i++) begin
      r.q[i] = requant_byte(sums[i]);
      if (int'(r.q[i]) > best) begin
        best      = int'(r.q[i]);
        r.max_idx = IDX_W'(i);
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Falling edge, new random m_ready
  task automatic next_cycle;
    @(negedge clk);
    m_ready = (($random(seed) & 3) != 0);
  endtask

  // Random idle gap, then hold the beat until it is taken
  task automatic send_beat(input in_beat_t b);
    while (($random(seed) & 3) == 0) begin
      s_valid = 1'b0;
      next_cycle();
    end
    s_beat  = b;
    s_valid = 1'b1;
    @(posedge clk);
    while (!s_ready) begin
      next_cycle();
      @(posedge clk);
    end
    next_cycle();
  endtask

  task automatic send_vector;
    in_beat_t    b;
    lane_bytes_t bias;
    int          n;
    int          nb;
    int          sums [LANES];

    // Sometimes two bias beats, the later one counts
    nb = (($random(seed) & 7) == 0) ? 2 : 1;
    for (int k = 0; k < nb; k++) begin
      b      = '0;
      b.kind = KIND_BIAS;
      for (int i = 0; i < LANES; i++) begin
        b.wgt[i] = sbyte_t'($random(seed));
      end
      bias = b.wgt;
      send_beat(b);
    end

    n = 1 + ($random(seed) & (MAX_BEATS - 1));
    for (int i = 0; i < LANES; i++) begin
      sums[i] = int'(bias[i]);
    end
    for (int j = 0; j < n; j++) begin
      b      = '0;
      b.kind = KIND_DATA;
      b.feat = sbyte_t'($random(seed));
      for (int i = 0; i < LANES; i++) begin
        b.wgt[i] = sbyte_t'($random(seed));
      end
      // Push the most negative byte in now and then
      if (($random(seed) & 15) == 0) begin
        b.feat = sbyte_t'(8'h80);
      end
      if (($random(seed) & 15) == 0) begin
        b.wgt[int'($random(seed) & 3)] = sbyte_t'(8'h80);
      end
      b.last = (j == n - 1);
      for (int i = 0; i < LANES; i++) begin
        sums[i] = sums[i] + int'(b.feat) * int'(b.wgt[i]);
      end
      send_beat(b);
    end
    exp_q.push_back(model_result(sums));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles with %0d results checked", cycles, checked);
      abort_run();
    end
  end

  always @(posedge clk) begin
    if (rstn && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("result word at %0t with no vector pending", $time);
        abort_run();
      end else begin
        check_result(m_result, exp_q.pop_front());
        checked++;
      end
    end
  end

  initial begin
    seed    = 32'h9911f074;
    cycles  = 0;
    checked = 0;
    rstn    = 1'b0;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;

    repeat (16) @(negedge clk);
    check_ready(s_ready, 1'b0);
    rstn = 1'b1;

    for (int v = 0; v < VECTORS; v++) begin
      send_vector();
    end
    s_valid = 1'b0;

    while (exp_q.size() != 0) begin
      next_cycle();
    end

    // Quiet period, a duplicated word would surface here
    repeat (8) begin
      next_cycle();
    end

    if (m_valid) begin
      $display("extra result word pending after the last vector");
      abort_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* tests/fc_assert.sv */
// Protocol assertions for the FC core, bound into fc_top.
// Covers reset quiet outputs, output hold under back-pressure and argmax.
`timescale 1ns/1ns

module fc_assert (
  input logic            clk,
  input logic            rstn,
  input logic            s_ready,
  input logic            m_valid,
  input logic            m_ready,
  input fc_pkg::result_t m_result
);
  import fc_pkg::*;

  logic max_ok;

  // Byte under max_idx is not smaller than any other byte
  always_comb begin
    max_ok = 1'b1;
    for (int i = 0; i < LANES; i++) begin
      if (m_result.q[i] > m_result.q[m_result.max_idx]) begin
        max_ok = 1'b0;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (!rstn && $past(!rstn)) |-> (!s_ready && !m_valid))
    else $error("s_ready or m_valid high during reset");

  a_result_hold: assert property (@(posedge clk) disable iff (!rstn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_result)))
    else $error("result word dropped or changed before m_ready");

  a_argmax: assert property (@(posedge clk) disable iff (!rstn)
    m_valid |-> max_ok)
    else $error("max_idx does not point at the largest byte");

endmodule

bind fc_top fc_assert i_assert (
  .clk      (clk),
  .rstn     (rstn),
  .s_ready  (s_ready),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_result (m_result)
);

/* rtl/fc_top.sv */
// FC compute core top level. Input beats pass decode, four MAC lanes and
// requant; one result word comes out per vector.
`timescale 1ns/1ns

module fc_top (
  input  logic             clk,
  input  logic             rstn,
  input  fc_pkg::in_beat_t s_beat,
  input  logic             s_valid,
  output logic             s_ready,
  output fc_pkg::result_t  m_result,
  output logic             m_valid,
  input  logic             m_ready
);
  import fc_pkg::*;

  logic             advance;
  mac_op_t          op;
  logic             op_valid;
  lane_bytes_t      bias;
  acc_t [LANES-1:0] lane_acc;
  // Lanes move in step, requant follows lane 0
  logic [LANES-1:0] lane_acc_valid;

  fc_decode i_decode (
    .clk      (clk),
    .rstn     (rstn),
    .s_beat   (s_beat),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .advance  (advance),
    .op       (op),
    .op_valid (op_valid),
    .bias     (bias)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    fc_mac_lane #(
      .LANE (i)
    ) i_lane (
      .clk       (clk),
      .rstn      (rstn),
      .advance   (advance),
      .op        (op),
      .op_valid  (op_valid),
      .acc       (lane_acc[i]),
      .acc_valid (lane_acc_valid[i])
    );
  end

  fc_requant i_requant (
    .clk       (clk),
    .rstn      (rstn),
    .acc       (lane_acc),
    .acc_valid (lane_acc_valid[0]),
    .bias      (bias),
    .m_result  (m_result),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .advance   (advance)
  );

endmodule

/* rtl/fc_requant.sv */
// Result stage of the FC core. Adds bias, applies ReLU with saturating
// requantization, picks the argmax and owns the output register and advance.
`timescale 1ns/1ns

module fc_requant (
  input  logic                                clk,
  input  logic                                rstn,
  input  fc_pkg::acc_t [fc_pkg::LANES-1:0]    acc,
  input  logic                                acc_valid,
  input  fc_pkg::lane_bytes_t                 bias,
  output fc_pkg::result_t                     m_result,
  output logic                                m_valid,
  input  logic                                m_ready,
  output logic                                advance
);
  import fc_pkg::*;

  acc_t [LANES-1:0]             sum;
  logic [LANES-1:0][DATA_W-1:0] q;
  logic [IDX_W-1:0]             max_idx;

  // Whole pipeline moves when the output slot is free or draining now
  assign advance = !m_valid || m_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Bias add and requantization
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      sum[i] = acc[i] + acc_t'(bias[i]);
      if (sum[i][ACC_W-1]) begin
        // ReLU
        q[i] = '0;
      end else if (|sum[i][ACC_W-2:Q_MSB+1]) begin
        q[i] = DATA_W'(SAT_VAL);
      end else begin
        q[i] = DATA_W'(sum[i][Q_MSB:Q_LSB]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Argmax
  ////////////////////////////////////////////////////////////////////////////

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    logic [DATA_W-1:0] best;

    best    = q[0];
    max_idx = '0;
    for (int i = 1; i < LANES; i++) begin
      if (q[i] > best) begin
        best    = q[i];
        max_idx = IDX_W'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid <= 1'b0;
    end else if (advance) begin
      m_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && acc_valid) begin
      m_result.q       <= q;
      m_result.max_idx <= max_idx;
    end
  end

endmodule

/* mac/fc_mac_lane.sv */
// One neuron lane: sign-magnitude multiply of feature and weight, then
// accumulation over a vector. Three register stages, all held by advance.
`timescale 1ns/1ns

module fc_mac_lane #(
  parameter int LANE = 0
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            advance,
  input  fc_pkg::mac_op_t op,
  input  logic            op_valid,
  output fc_pkg::acc_t    acc,
  output logic            acc_valid
);
  import fc_pkg::*;

  sbyte_t              wgt;
  logic [DATA_W-1:0]   feat_mag;
  logic [DATA_W-1:0]   wgt_mag;

  // Stage 1, operand magnitudes and product sign
  logic                v1;
  logic [DATA_W-1:0]   feat_mag_q;
  logic [DATA_W-1:0]   wgt_mag_q;
  logic                sign1_q;
  logic                first1_q;
  logic                last1_q;

  // Stage 2, magnitude product
  logic                v2;
  logic [2*DATA_W-1:0] prod_q;
  logic                sign2_q;
  logic                first2_q;
  logic                last2_q;

  // Stage 3, accumulator
  acc_t                prod_ext;
  acc_t                prod_signed;
  acc_t                acc_q;

  assign wgt = op.wgt[LANE];

  // |-128| is 8'h80, still fits as unsigned
  assign feat_mag = op.feat[DATA_W-1] ? -op.feat : op.feat;
  assign wgt_mag  = wgt[DATA_W-1] ? -wgt : wgt;

  ////////////////////////////////////////////////////////////////////////////
  // Valid chain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      acc_valid <= 1'b0;
    end else if (advance) begin
      v1        <= op_valid;
      v2        <= v1;
      acc_valid <= v2 && last2_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 and 2
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      feat_mag_q <= feat_mag;
      wgt_mag_q  <= wgt_mag;
      sign1_q    <= op.feat[DATA_W-1] ^ wgt[DATA_W-1];
      first1_q   <= op.first;
      last1_q    <= op.last;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      prod_q   <= feat_mag_q * wgt_mag_q;
      sign2_q  <= sign1_q;
      first2_q <= first1_q;
      last2_q  <= last1_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 3, sign restore and accumulate
  ////////////////////////////////////////////////////////////////////////////

  // Zero extension, the product register holds a magnitude
  assign prod_ext    = acc_t'(prod_q);
  assign prod_signed = sign2_q ? -prod_ext : prod_ext;

  // First op of a vector replaces the running sum
  always_ff @(posedge clk) begin
    if (advance && v2) begin
      if (first2_q) begin
        acc_q <= prod_signed;
      end else begin
        acc_q <= acc_q + prod_signed;
      end
    end
  end

  assign acc = acc_q;

endmodule

/* rtl/fc_decode.sv */
// Input stage of the FC core. Accepts beats, keeps the biases and issues
// one MAC operation per DATA beat with first/last marks.
`timescale 1ns/1ns

module fc_decode (
  input  logic                clk,
  input  logic                rstn,
  input  fc_pkg::in_beat_t    s_beat,
  input  logic                s_valid,
  output logic                s_ready,
  input  logic                advance,
  output fc_pkg::mac_op_t     op,
  output logic                op_valid,
  output fc_pkg::lane_bytes_t bias
);
  import fc_pkg::*;

  logic        run;
  logic        accept;
  logic        start;
  lane_bytes_t bias_q;
  // Bias travels alongside its ops, one entry per pipeline stage up to requant
  lane_bytes_t bias_dly [0:MAC_STAGES];

  // Input opens one cycle after reset release
  always_ff @(posedge clk) begin
    if (!rstn) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign s_ready = advance && run;
  assign accept  = s_valid && s_ready;

  // Bias registers and start-of-vector tracking
  always_ff @(posedge clk) begin
    if (!rstn) begin
      bias_q <= '0;
      start  <= 1'b1;
    end else if (accept) begin
      if (s_beat.kind == KIND_BIAS) begin
        bias_q <= s_beat.wgt;
        start  <= 1'b1;
      end else begin
        start <= s_beat.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      op_valid <= 1'b0;
    end else if (advance) begin
      op_valid <= accept && (s_beat.kind == KIND_DATA);
    end
  end

  // Op payload
  always_ff @(posedge clk) begin
    if (accept && (s_beat.kind == KIND_DATA)) begin
      op.feat  <= s_beat.feat;
      op.wgt   <= s_beat.wgt;
      op.first <= start;
      op.last  <= s_beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      bias_dly[0] <= bias_q;
      for (int k = 1; k <= MAC_STAGES; k++) begin
        bias_dly[k] <= bias_dly[k-1];
      end
    end
  end

  assign bias = bias_dly[MAC_STAGES];

endmodule

/* common/fc_pkg.sv */
// Shared widths, beat encodings and the structs passed between the FC blocks.
// Modules import this package inside their bodies and name its types in their ports.

package fc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and requantization constants
  ////////////////////////////////////////////////////////////////////////////

  // Neuron lanes working on the same feature
  localparam int LANES = 4;

  // Feature, weight, bias and output byte
  localparam int DATA_W = 8;

  // Accumulator and biased sum
  localparam int ACC_W = 28;

  // Output byte window of the biased sum
  localparam int Q_LSB = 6;
  localparam int Q_MSB = 12;

  // Saturated output when bits above Q_MSB are set
  localparam int SAT_VAL = 127;

  // Argmax index width
  localparam int IDX_W = 2;

  // Register stages inside one MAC lane
  localparam int MAC_STAGES = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    KIND_BIAS = 1'b0,
    KIND_DATA = 1'b1
  } beat_kind_e;

  // One signed byte, elements of the lane vectors stay signed
  typedef logic signed [DATA_W-1:0] sbyte_t;

  // One signed byte per lane, weights or biases
  typedef sbyte_t [LANES-1:0] lane_bytes_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  // Input beat, wgt carries the biases on a BIAS beat
  typedef struct packed {
    beat_kind_e  kind;
    sbyte_t      feat;
    lane_bytes_t wgt;
    logic        last;
  } in_beat_t;

  // Operation broadcast to every lane
  typedef struct packed {
    sbyte_t      feat;
    lane_bytes_t wgt;
    logic        first;
    logic        last;
  } mac_op_t;

  // Output word, requantized bytes and index of the largest
  typedef struct packed {
    logic [LANES-1:0][DATA_W-1:0] q;
    logic [IDX_W-1:0]             max_idx;
  } result_t;

endpackage
